// File: vlog.f
hdl/mem_pkg.sv
hdl/cache_tags.sv
hdl/line_ram.sv
hdl/line_fetcher.sv
hdl/ifetch_unit.sv
hdl/data_unit.sv
hdl/bus_arbiter.sv
hdl/mem_unit_top.sv
tests/bus_model.sv
tests/tb_mem_unit.sv

// File: tests/tb_mem_unit.sv
`timescale 1ns/1ps

module tb_mem_unit import mem_pkg::*; ();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int WAIT_LIMIT      = 500;
  localparam addr_t IP_A = 32'h0000_1140;   // set 5
  localparam addr_t IP_B = 32'h0000_2240;   // set 9
  localparam addr_t IP_E = 32'h0000_3500;   // set 20
  localparam addr_t IP_C = 32'h0000_3780;   // set 30

  logic              clk;
  logic              rst;
  addr_t             ip_i;
  logic              ihit_o;
  line_t             ic_line_o;
  logic              mem_req_i;
  mem_op_e           mem_op_i;
  mem_func_e         mem_func_i;
  addr_t             ea_i;
  logic [DATA_W-1:0] st_dat_i;
  logic              ready_o;
  logic              done_o;
  logic [DATA_W-1:0] res_o;
  logic              cyc_o;
  logic              stb_o;
  logic              we_o;
  logic              vpa_o;
  logic [SEL_W-1:0]  sel_o;
  addr_t             adr_o;
  beat_t             dat_o;
  logic              ack_i;
  beat_t             dat_i;
  int                bus_beats;

  addr_t            log_adr [$];
  logic             log_we [$];
  logic             log_vpa [$];
  logic [SEL_W-1:0] log_sel [$];
  logic [7:0]       shadow [addr_t];   // bytes the testbench has stored

  integer seed = 93308;
  int     errors;
  int     err_mark;
  int     pass_cnt;
  int     fail_cnt;
  string  test_name;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  mem_unit_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .ip_i       (ip_i),
    .ihit_o     (ihit_o),
    .ic_line_o  (ic_line_o),
    .mem_req_i  (mem_req_i),
    .mem_op_i   (mem_op_i),
    .mem_func_i (mem_func_i),
    .ea_i       (ea_i),
    .st_dat_i   (st_dat_i),
    .ready_o    (ready_o),
    .done_o     (done_o),
    .res_o      (res_o),
    .cyc_o      (cyc_o),
    .stb_o      (stb_o),
    .we_o       (we_o),
    .vpa_o      (vpa_o),
    .sel_o      (sel_o),
    .adr_o      (adr_o),
    .dat_o      (dat_o),
    .ack_i      (ack_i),
    .dat_i      (dat_i)
  );

  bus_model #(.SEED(93308)) u_bus (
    .clk     (clk),
    .rst     (rst),
    .cyc_i   (cyc_o),
    .stb_i   (stb_o),
    .we_i    (we_o),
    .sel_i   (sel_o),
    .adr_i   (adr_o),
    .dat_i   (dat_o),
    .ack_o   (ack_i),
    .dat_o   (dat_i),
    .beats_o (bus_beats)
  );

  // bus protocol rules on every cycle
  assert property (@(posedge clk) disable iff (rst) stb_o |-> cyc_o)
    else begin
      $display("ERROR %s: stb_o high while cyc_o is low", test_name);
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst) vpa_o |-> !we_o)
    else begin
      $display("ERROR %s: vpa_o high on a write", test_name);
      errors++;
    end

  // one entry per acked beat
  always @(negedge clk) begin
    if (!rst && stb_o && ack_i) begin
      log_adr.push_back(adr_o);
      log_we.push_back(we_o);
      log_vpa.push_back(vpa_o);
      log_sel.push_back(sel_o);
    end
  end

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [7:0] mem_byte(addr_t a);
    if (shadow.exists(a))
      return shadow[a];
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic line_t line_at(addr_t a);
    line_t l;
    addr_t base;
    base = {a[ADDR_W-1:6], 6'b0};
    for (int b = 0; b < LINE_W/8; b++)
      l[b*8 +: 8] = mem_byte(base + b);   // little endian bytes
    return l;
  endfunction

  function automatic int size_of(mem_func_e f);
    case (f)
      f_byte, f_ubyte: return 1;
      f_half, f_uhalf: return 2;
      f_word, f_uword: return 4;
      default:         return 8;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] load_value(mem_func_e f, addr_t a);
    logic [DATA_W-1:0] raw;
    int n;
    raw = '0;
    n = size_of(f);
    for (int i = 0; i < n; i++)
      raw[i*8 +: 8] = mem_byte(a + i);
    case (f)
      f_byte:  return {{56{raw[7]}}, raw[7:0]};
      f_half:  return {{48{raw[15]}}, raw[15:0]};
      f_word:  return {{32{raw[31]}}, raw[31:0]};
      default: return raw;   // upper bytes already zero
    endcase
  endfunction

  function automatic addr_t rand_in_line(addr_t base, mem_func_e f);
    int sz;
    sz = size_of(f);
    return base + rand_below(4) * 16 + rand_below(16 / sz) * sz;
  endfunction

  task automatic expect_equal(input string what, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
    assert (exp === act)
      else begin
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
        errors++;
      end
  endtask

  task automatic expect_true(input string what, input logic cond);
    assert (cond === 1'b1)
      else begin
        $display("ERROR %s: %s", test_name, what);
        errors++;
      end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    if (errors == err_mark) begin
      $display("test %s: passed", test_name);
      pass_cnt++;
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - err_mark);
      fail_cnt++;
    end
  endtask

  task automatic clear_log();
    log_adr.delete();
    log_we.delete();
    log_vpa.delete();
    log_sel.delete();
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true("ready_o did not return high", ready_o);
  endtask

  // one data side request and the result seen with done_o
  task automatic access(input mem_op_e op, input mem_func_e f, input addr_t ea,
                        input logic [DATA_W-1:0] sd, output logic [DATA_W-1:0] res,
                        output logic rdy_at_done);
    int n;
    wait_ready();
    @(posedge clk);
    clear_log();
    mem_req_i  <= 1'b1;
    mem_op_i   <= op;
    mem_func_i <= f;
    ea_i       <= ea;
    st_dat_i   <= sd;
    @(posedge clk);
    mem_req_i <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!done_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true("done_o never pulsed", done_o);
    res         = res_o;
    rdy_at_done = ready_o;
    wait_ready();
  endtask

  task automatic check_single(input addr_t ea, input mem_func_e f, input logic we,
                              input int idx);
    logic [SEL_W-1:0] mask;
    if (log_adr.size() <= idx) begin
      expect_true("single bus beat missing", 1'b0);
      return;
    end
    mask = SEL_W'((1 << size_of(f)) - 1) << ea[3:0];
    expect_equal("beat address", {ea[ADDR_W-1:4], 4'b0}, log_adr[idx]);
    expect_equal("beat sel_o", mask, log_sel[idx]);
    expect_equal("beat we_o", we, log_we[idx]);
    expect_equal("beat vpa_o", 1'b0, log_vpa[idx]);
  endtask

  task automatic check_refill(input addr_t ea, input int first);
    if (log_adr.size() < first + BEATS) begin
      expect_true("refill beats missing", 1'b0);
      return;
    end
    for (int k = 0; k < BEATS; k++) begin
      expect_equal("refill address", {ea[ADDR_W-1:6], 6'b0} + 16 * k, log_adr[first+k]);
      expect_equal("refill sel_o", {SEL_W{1'b1}}, log_sel[first+k]);
      expect_equal("refill we_o", 1'b0, log_we[first+k]);
    end
  endtask

  task automatic load_and_check(input mem_func_e f, input addr_t ea, input int exp_beats);
    logic [DATA_W-1:0] res;
    logic rdy;
    access(op_load, f, ea, '0, res, rdy);
    expect_equal($sformatf("%s load at %h", f.name(), ea), load_value(f, ea), res);
    expect_equal("bus beats", exp_beats, log_adr.size());
    if (exp_beats >= 1)
      check_single(ea, f, 1'b0, 0);
    if (exp_beats == 1 + BEATS) begin
      check_refill(ea, 1);
      expect_true("ready_o high at done_o before the refill", !rdy);
    end
  endtask

  task automatic store_and_check(input mem_func_e f, input addr_t ea, input int exp_beats);
    logic [DATA_W-1:0] sd;
    logic [DATA_W-1:0] res;
    logic rdy;
    sd = {$random(seed), $random(seed)};
    access(op_store, f, ea, sd, res, rdy);
    expect_equal("store bus beats", 1, log_adr.size());
    check_single(ea, f, 1'b1, 0);
    for (int i = 0; i < size_of(f); i++)
      shadow[ea + i] = sd[i*8 +: 8];
    load_and_check(f, ea, exp_beats);   // readback
  endtask

  task automatic fetch_and_check(input addr_t ip);
    int n;
    @(posedge clk);
    clear_log();
    ip_i <= ip;
    @(negedge clk);
    expect_true("ihit_o high for a new line", !ihit_o);
    n = 0;
    while (!ihit_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    expect_true("ihit_o never rose", ihit_o);
    expect_equal("fetch beats", BEATS, log_adr.size());
    for (int k = 0; k < BEATS && k < log_adr.size(); k++) begin
      expect_equal("fetch address", {ip[ADDR_W-1:6], 6'b0} + 16 * k, log_adr[k]);
      expect_equal("fetch vpa_o", 1'b1, log_vpa[k]);
      expect_equal("fetch sel_o", {SEL_W{1'b1}}, log_sel[k]);
    end
    expect_equal("ic_line_o", line_at(ip), ic_line_o);
  endtask

  task automatic simultaneous_misses(input addr_t ip, input mem_func_e f, input addr_t ea);
    int n;
    logic got_done;
    logic [DATA_W-1:0] res;
    addr_t f_adr [$];
    addr_t d_adr [$];
    @(posedge clk);
    clear_log();
    ip_i       <= ip;
    mem_req_i  <= 1'b1;
    mem_op_i   <= op_load;
    mem_func_i <= f;
    ea_i       <= ea;
    @(posedge clk);
    mem_req_i <= 1'b0;
    got_done = 1'b0;
    n = 0;
    while (!(got_done && ihit_o && ready_o) && n < CYCLES_PER_TEST / 2) begin
      @(negedge clk);
      if (done_o) begin
        got_done = 1'b1;
        res = res_o;
      end
      n++;
    end
    expect_true("data access never finished", got_done && ready_o);
    expect_true("instruction refill never finished", ihit_o);
    expect_equal("load result", load_value(f, ea), res);
    if (log_vpa.size() > 0)
      expect_equal("vpa_o of first bus cycle", 1'b1, log_vpa[0]);
    foreach (log_adr[i])
      if (log_vpa[i])
        f_adr.push_back(log_adr[i]);
      else
        d_adr.push_back(log_adr[i]);
    expect_equal("fetch beats", BEATS, f_adr.size());
    expect_equal("data beats", 1 + BEATS, d_adr.size());
    for (int k = 0; k < BEATS && k < f_adr.size(); k++)
      expect_equal("fetch address", {ip[ADDR_W-1:6], 6'b0} + 16 * k, f_adr[k]);
    if (d_adr.size() > 0)
      expect_equal("data beat address", {ea[ADDR_W-1:4], 4'b0}, d_adr[0]);
    for (int k = 0; k < BEATS && k + 1 < d_adr.size(); k++)
      expect_equal("refill address", {ea[ADDR_W-1:6], 6'b0} + 16 * k, d_adr[k+1]);
    expect_equal("ic_line_o", line_at(ip), ic_line_o);
  endtask

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * CYCLES_PER_TEST);
    $display("Regression failed");
    $finish;
  end

  initial begin
    addr_t     ea;
    addr_t     base;
    addr_t     line_d;
    mem_func_e f;
    int        beats0;
    errors     = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    test_name  = "reset";
    rst        = 1'b1;
    ip_i       = IP_A;   // first instruction line
    mem_req_i  = 1'b0;
    mem_op_i   = op_load;
    mem_func_i = f_byte;
    ea_i       = '0;
    st_dat_i   = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start_test("reset");
    @(negedge clk);
    expect_true("bus strobes low after reset", !cyc_o && !stb_o && !vpa_o && !we_o);
    expect_true("done_o low after reset", !done_o);
    expect_true("ready_o high after reset", ready_o);
    finish_test();

    start_test("ifetch_miss_hit");
    fetch_and_check(IP_A);
    fetch_and_check(IP_B);
    @(posedge clk);
    ip_i <= IP_A;
    @(negedge clk);
    beats0 = bus_beats;
    expect_true("ihit_o low on a cached line", ihit_o);
    expect_equal("ic_line_o", line_at(IP_A), ic_line_o);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      expect_true("bus cycle started on a cached line", !cyc_o);
    end
    expect_equal("bus cycles on a hit", beats0, bus_beats);
    finish_test();

    start_test("uncached_loads");
    for (int fi = 0; fi < 7; fi++) begin
      f  = mem_func_e'(fi);
      ea = 32'h8000_0000 | addr_t'(rand_below(65536) << 4);
      ea = ea + rand_below(16 / size_of(f)) * size_of(f);
      load_and_check(f, ea, 1);
    end
    finish_test();

    start_test("load_miss_then_hit");
    base = 32'h0000_4000 | addr_t'(rand_below(16) << 6);
    f    = mem_func_e'(rand_below(7));
    load_and_check(f, rand_in_line(base, f), 1 + BEATS);
    for (int i = 0; i < 6; i++) begin
      f = mem_func_e'(rand_below(7));
      load_and_check(f, rand_in_line(base, f), 0);
    end
    finish_test();

    start_test("stores");
    base = 32'h0000_6000 | addr_t'((16 + rand_below(16)) << 6);
    f    = mem_func_e'(rand_below(7));
    load_and_check(f, rand_in_line(base, f), 1 + BEATS);
    for (int i = 0; i < 4; i++) begin
      f = mem_func_e'(rand_below(4));   // size only
      store_and_check(f, rand_in_line(base, f), 0);
    end
    for (int i = 0; i < 2; i++) begin
      f = mem_func_e'(rand_below(4));
      store_and_check(f, rand_in_line(32'h8001_0000 | addr_t'(rand_below(256) << 6), f), 1);
    end
    finish_test();

    start_test("arbitration");
    fetch_and_check(IP_E);   // leaves the fetch side owning the bus
    line_d = 32'h0000_7000 | addr_t'((32 + rand_below(16)) << 6);
    f      = mem_func_e'(rand_below(7));
    simultaneous_misses(IP_C, f, rand_in_line(line_d, f));
    f = mem_func_e'(rand_below(7));
    load_and_check(f, rand_in_line(line_d, f), 0);
    finish_test();

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tests/bus_model.sv
`timescale 1ns/1ps

module bus_model import mem_pkg::*; #(
  parameter int SEED = 93308
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  logic [SEL_W-1:0] sel_i,
  input  addr_t            adr_i,
  input  beat_t            dat_i,
  output logic             ack_o,
  output beat_t            dat_o,
  output int               beats_o
);

  logic [7:0] mem [addr_t];   // written bytes only
  integer     seed = SEED;
  logic       busy;
  int         delay;
  addr_t      base;

  function automatic logic [7:0] read_byte(addr_t a);
    if (mem.exists(a))
      return mem[a];
    return a[7:0] ^ a[15:8];   // fill pattern
  endfunction

  initial begin
    ack_o   = 1'b0;
    dat_o   = '0;
    beats_o = 0;
  end

  // one beat per strobe, answered after a random wait
  always @(posedge clk) begin
    if (rst) begin
      ack_o   <= 1'b0;
      busy    <= 1'b0;
      beats_o <= 0;
    end else if (!(cyc_i && stb_i)) begin
      ack_o <= 1'b0;   // ack falls once the strobe is gone
      busy  <= 1'b0;
    end else if (!ack_o) begin
      if (!busy) begin
        busy  <= 1'b1;
        delay <= $random(seed) & 3;
      end else if (delay != 0) begin
        delay <= delay - 1;
      end else begin
        ack_o   <= 1'b1;
        beats_o <= beats_o + 1;
        base = {adr_i[ADDR_W-1:4], 4'b0};
        for (int i = 0; i < SEL_W; i++) begin
          if (we_i && sel_i[i])
            mem[base + i] = dat_i[i*8 +: 8];
          dat_o[i*8 +: 8] <= read_byte(base + i);
        end
      end
    end
  end

endmodule

// File: hdl/mem_unit_top.sv
`timescale 1ns/1ps

module mem_unit_top import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  addr_t             ip_i,
  output logic              ihit_o,
  output line_t             ic_line_o,
  input  logic              mem_req_i,
  input  mem_op_e           mem_op_i,
  input  mem_func_e         mem_func_i,
  input  addr_t             ea_i,
  input  logic [DATA_W-1:0] st_dat_i,
  output logic              ready_o,
  output logic              done_o,
  output logic [DATA_W-1:0] res_o,
  output logic              cyc_o,
  output logic              stb_o,
  output logic              we_o,
  output logic              vpa_o,
  output logic [SEL_W-1:0]  sel_o,
  output addr_t             adr_o,
  output beat_t             dat_o,
  input  logic              ack_i,
  input  beat_t             dat_i
);

  // fetch peer
  logic             f_cyc;
  logic             f_stb;
  logic             f_vpa;
  addr_t            f_adr;
  logic             f_ack;
  beat_t            f_dat;
  // data peer
  logic             d_cyc;
  logic             d_stb;
  logic             d_we;
  logic [SEL_W-1:0] d_sel;
  addr_t            d_adr;
  beat_t            d_wdat;
  logic             d_ack;
  beat_t            d_rdat;

  ifetch_unit u_ifetch (
    .clk       (clk),
    .rst       (rst),
    .ip_i      (ip_i),
    .ihit_o    (ihit_o),
    .ic_line_o (ic_line_o),
    .cyc_o     (f_cyc),
    .stb_o     (f_stb),
    .vpa_o     (f_vpa),
    .adr_o     (f_adr),
    .ack_i     (f_ack),
    .dat_i     (f_dat)
  );

  data_unit u_data (
    .clk        (clk),
    .rst        (rst),
    .mem_req_i  (mem_req_i),
    .mem_op_i   (mem_op_i),
    .mem_func_i (mem_func_i),
    .ea_i       (ea_i),
    .st_dat_i   (st_dat_i),
    .ready_o    (ready_o),
    .done_o     (done_o),
    .res_o      (res_o),
    .cyc_o      (d_cyc),
    .stb_o      (d_stb),
    .we_o       (d_we),
    .sel_o      (d_sel),
    .adr_o      (d_adr),
    .dat_o      (d_wdat),
    .ack_i      (d_ack),
    .dat_i      (d_rdat)
  );

  bus_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .f_cyc_i (f_cyc),
    .f_stb_i (f_stb),
    .f_vpa_i (f_vpa),
    .f_adr_i (f_adr),
    .f_ack_o (f_ack),
    .f_dat_o (f_dat),
    .d_cyc_i (d_cyc),
    .d_stb_i (d_stb),
    .d_we_i  (d_we),
    .d_sel_i (d_sel),
    .d_adr_i (d_adr),
    .d_dat_i (d_wdat),
    .d_ack_o (d_ack),
    .d_dat_o (d_rdat),
    .cyc_o   (cyc_o),
    .stb_o   (stb_o),
    .we_o    (we_o),
    .vpa_o   (vpa_o),
    .sel_o   (sel_o),
    .adr_o   (adr_o),
    .dat_o   (dat_o),
    .ack_i   (ack_i),
    .dat_i   (dat_i)
  );

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import mem_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  // fetch peer
  input  logic             f_cyc_i,
  input  logic             f_stb_i,
  input  logic             f_vpa_i,
  input  addr_t            f_adr_i,
  output logic             f_ack_o,
  output beat_t            f_dat_o,
  // data peer
  input  logic             d_cyc_i,
  input  logic             d_stb_i,
  input  logic             d_we_i,
  input  logic [SEL_W-1:0] d_sel_i,
  input  addr_t            d_adr_i,
  input  beat_t            d_dat_i,
  output logic             d_ack_o,
  output beat_t            d_dat_o,
  // external bus
  output logic             cyc_o,
  output logic             stb_o,
  output logic             we_o,
  output logic             vpa_o,
  output logic [SEL_W-1:0] sel_o,
  output addr_t            adr_o,
  output beat_t            dat_o,
  input  logic             ack_i,
  input  beat_t            dat_i
);

  logic grant_d;     // 0 fetch owns the bus, 1 data
  logic owner_cyc;

  assign owner_cyc = grant_d ? d_cyc_i : f_cyc_i;

  // hand over only between cycles, fetch has priority
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_d <= 1'b0;
    end else if (!owner_cyc && !ack_i) begin
      if (f_cyc_i)
        grant_d <= 1'b0;
      else if (d_cyc_i)
        grant_d <= 1'b1;
    end
  end

  assign cyc_o = owner_cyc;
  assign stb_o = grant_d ? d_stb_i : f_stb_i;
  assign we_o  = grant_d & d_we_i;   // fetch never writes
  assign vpa_o = !grant_d & f_vpa_i;
  assign sel_o = grant_d ? d_sel_i : {SEL_W{f_cyc_i}};
  assign adr_o = grant_d ? d_adr_i : f_adr_i;
  assign dat_o = d_dat_i;

  // the waiting peer sees no ack
  assign f_ack_o = !grant_d & ack_i;
  assign d_ack_o = grant_d & ack_i;
  assign f_dat_o = grant_d ? '0 : dat_i;
  assign d_dat_o = grant_d ? dat_i : '0;

endmodule

// File: hdl/data_unit.sv
`timescale 1ns/1ps

module data_unit import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_req_i,
  input  mem_op_e           mem_op_i,
  input  mem_func_e         mem_func_i,
  input  addr_t             ea_i,
  input  logic [DATA_W-1:0] st_dat_i,
  output logic              ready_o,
  output logic              done_o,
  output logic [DATA_W-1:0] res_o,
  output logic              cyc_o,
  output logic              stb_o,
  output logic              we_o,
  output logic [SEL_W-1:0]  sel_o,
  output addr_t             adr_o,
  output beat_t             dat_o,
  input  logic              ack_i,
  input  beat_t             dat_i
);

  typedef enum logic [2:0] {
    ds_idle,
    ds_lookup,
    ds_wait_ack,
    ds_wait_nack,
    ds_refill
  } ds_state_e;

  ds_state_e           state;
  mem_op_e             op_q;
  mem_func_e           func_q;
  addr_t               ea_q;
  logic [DATA_W-1:0]   st_dat_q;
  beat_t               beat_q;     // read beat from the bus
  logic                b_cyc;
  logic                b_we;
  logic [SEL_W-1:0]    b_sel;
  beat_t               b_dat;
  logic                tag_hit;
  logic                hit;
  logic                cacheable;
  logic                fill;
  logic                line_wr;
  logic                fetch_start;
  logic                fetch_done;
  logic                f_cyc;
  logic                f_stb;
  addr_t               f_adr;
  way_t                hit_way;
  way_t                victim_way;
  way_t                wr_way;
  line_t               rd_line;
  line_t               fetch_line;
  line_t               merged_line;
  line_t               wr_line;
  line_t               line_data;
  logic [LINE_W/8-1:0] line_sel;
  logic [SEL_W-1:0]    size_sel;
  logic [SEL_W-1:0]    beat_sel;
  beat_t               beat_data;
  beat_t               src_beat;
  beat_t               shifted;
  logic [DATA_W-1:0]   raw;
  logic [DATA_W-1:0]   ext;

  cache_tags u_tags (
    .clk          (clk),
    .rst          (rst),
    .lookup_adr_i (ea_q),
    .fill_i       (fill),
    .fill_adr_i   (ea_q),
    .hit_o        (tag_hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  line_ram u_lines (
    .clk       (clk),
    .wr_i      (line_wr),
    .wr_way_i  (wr_way),
    .wr_idx_i  (ea_q[OFS_W +: IDX_W]),
    .wr_line_i (wr_line),
    .rd_way_i  (hit_way),
    .rd_idx_i  (ea_q[OFS_W +: IDX_W]),
    .rd_line_o (rd_line)
  );

  line_fetcher u_fetch (
    .clk        (clk),
    .rst        (rst),
    .start_i    (fetch_start),
    .line_adr_i (ea_q),
    .cyc_o      (f_cyc),
    .stb_o      (f_stb),
    .adr_o      (f_adr),
    .ack_i      (ack_i),
    .dat_i      (dat_i),
    .done_o     (fetch_done),
    .line_o     (fetch_line)
  );

  assign cacheable = !ea_q[IO_BIT];
  assign hit       = tag_hit && cacheable;
  assign ready_o   = (state == ds_idle);

  // byte selects and data lanes within the beat
  always_comb begin
    case (func_q)
      f_byte, f_ubyte: size_sel = SEL_W'(8'h01);
      f_half, f_uhalf: size_sel = SEL_W'(8'h03);
      f_word, f_uword: size_sel = SEL_W'(8'h0f);
      default:         size_sel = SEL_W'(8'hff);
    endcase
  end

  assign beat_sel  = size_sel << ea_q[3:0];
  assign beat_data = beat_t'(st_dat_q) << {ea_q[3:0], 3'b0};

  // store hit merge, same lanes moved up to the beat's slot in the line
  assign line_sel  = (LINE_W/8)'(beat_sel) << {ea_q[5:4], 4'b0};
  assign line_data = line_t'(beat_data) << {ea_q[5:4], 7'b0};

  always_comb begin
    for (int b = 0; b < LINE_W/8; b++)
      merged_line[b*8 +: 8] = line_sel[b] ? line_data[b*8 +: 8] : rd_line[b*8 +: 8];
  end

  assign fill    = (state == ds_refill) && fetch_done;
  assign line_wr = fill || (state == ds_lookup && op_q == op_store && hit);
  assign wr_way  = fill ? victim_way : hit_way;
  assign wr_line = fill ? fetch_line : merged_line;

  // refill only after a cacheable load miss
  assign fetch_start = (state == ds_wait_nack) && !ack_i && (op_q == op_load) && cacheable;

  // load result, from the cached line on a hit, else from the bus beat
  assign src_beat = (state == ds_lookup) ? rd_line[ea_q[5:4]*BEAT_W +: BEAT_W] : beat_q;
  assign shifted  = src_beat >> {ea_q[3:0], 3'b0};
  assign raw      = shifted[DATA_W-1:0];

  always_comb begin
    case (func_q)
      f_byte:  ext = {{56{raw[7]}}, raw[7:0]};
      f_half:  ext = {{48{raw[15]}}, raw[15:0]};
      f_word:  ext = {{32{raw[31]}}, raw[31:0]};
      f_ubyte: ext = {56'b0, raw[7:0]};
      f_uhalf: ext = {48'b0, raw[15:0]};
      f_uword: ext = {32'b0, raw[31:0]};
      default: ext = raw;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ds_idle;
      b_cyc  <= 1'b0;
      b_we   <= 1'b0;
      b_sel  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        ds_idle:
          if (mem_req_i)
            state <= ds_lookup;
        ds_lookup:
          if (op_q == op_load && hit) begin
            done_o <= 1'b1;   // no bus cycle
            state  <= ds_idle;
          end else begin
            b_cyc <= 1'b1;
            b_we  <= (op_q == op_store);
            b_sel <= beat_sel;
            state <= ds_wait_ack;
          end
        ds_wait_ack:
          if (ack_i) begin
            b_cyc <= 1'b0;
            b_we  <= 1'b0;
            b_sel <= '0;
            state <= ds_wait_nack;
          end
        ds_wait_nack:
          if (!ack_i) begin
            done_o <= 1'b1;
            state  <= fetch_start ? ds_refill : ds_idle;
          end
        ds_refill:
          if (fetch_done)
            state <= ds_idle;
        default: state <= ds_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ds_idle && mem_req_i) begin
      op_q     <= mem_op_i;
      func_q   <= mem_func_i;
      ea_q     <= ea_i;
      st_dat_q <= st_dat_i;
    end
    if (state == ds_lookup)
      b_dat <= beat_data;
    if (state == ds_wait_ack && ack_i)
      beat_q <= dat_i;
    if (state == ds_lookup || (state == ds_wait_nack && !ack_i))
      res_o <= ext;   // valid with done_o
  end

  // fetcher and single beat never run together
  assign cyc_o = b_cyc | f_cyc;
  assign stb_o = b_cyc | f_stb;
  assign we_o  = b_we;
  assign sel_o = f_cyc ? '1 : b_sel;
  assign adr_o = f_cyc ? f_adr : {ea_q[ADDR_W-1:4], 4'b0};
  assign dat_o = b_dat;

endmodule

// File: hdl/ifetch_unit.sv
`timescale 1ns/1ps

module ifetch_unit import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t ip_i,
  output logic  ihit_o,
  output line_t ic_line_o,
  output logic  cyc_o,
  output logic  stb_o,
  output logic  vpa_o,
  output addr_t adr_o,
  input  logic  ack_i,
  input  beat_t dat_i
);

  typedef enum logic {
    ic_idle,
    ic_refill
  } ic_state_e;

  ic_state_e state;
  way_t      hit_way;
  way_t      victim_way;
  logic      fetch_start;
  logic      fetch_done;
  logic      fill;
  line_t     fetch_line;

  cache_tags u_tags (
    .clk          (clk),
    .rst          (rst),
    .lookup_adr_i (ip_i),
    .fill_i       (fill),
    .fill_adr_i   (ip_i),   // ip held until the hit shows
    .hit_o        (ihit_o),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  line_ram u_lines (
    .clk       (clk),
    .wr_i      (fill),
    .wr_way_i  (victim_way),
    .wr_idx_i  (ip_i[OFS_W +: IDX_W]),
    .wr_line_i (fetch_line),
    .rd_way_i  (hit_way),
    .rd_idx_i  (ip_i[OFS_W +: IDX_W]),
    .rd_line_o (ic_line_o)
  );

  line_fetcher u_fetch (
    .clk        (clk),
    .rst        (rst),
    .start_i    (fetch_start),
    .line_adr_i (ip_i),
    .cyc_o      (cyc_o),
    .stb_o      (stb_o),
    .adr_o      (adr_o),
    .ack_i      (ack_i),
    .dat_i      (dat_i),
    .done_o     (fetch_done),
    .line_o     (fetch_line)
  );

  assign fetch_start = (state == ic_idle) && !ihit_o;   // once per miss
  assign fill        = (state == ic_refill) && fetch_done;
  assign vpa_o       = cyc_o;   // every fetcher beat is an instruction fetch

  always_ff @(posedge clk) begin
    if (rst)
      state <= ic_idle;
    else if (state == ic_idle && fetch_start)
      state <= ic_refill;
    else if (fill)
      state <= ic_idle;   // tag and line land on this edge
  end

endmodule

// File: hdl/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start_i,
  input  addr_t line_adr_i,
  output logic  cyc_o,
  output logic  stb_o,
  output addr_t adr_o,
  input  logic  ack_i,
  input  beat_t dat_i,
  output logic  done_o,
  output line_t line_o
);

  typedef enum logic [1:0] {
    lf_idle,
    lf_strobe,
    lf_wait_ack,
    lf_wait_nack
  } lf_state_e;

  lf_state_e                  state;
  logic [$clog2(BEATS)-1:0]   beat_cnt;
  logic [ADDR_W-OFS_W-1:0]    line_base;
  logic                       cyc_q;

  assign cyc_o = cyc_q;
  assign stb_o = cyc_q;   // single beat cycles
  assign adr_o = {line_base, beat_cnt, 4'b0};   // ascending 16 byte beats

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= lf_idle;
      cyc_q    <= 1'b0;
      done_o   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      done_o <= 1'b0;
      case (state)
        lf_idle:
          if (start_i) begin
            beat_cnt <= '0;
            state    <= lf_strobe;
          end
        lf_strobe: begin
          cyc_q <= 1'b1;
          state <= lf_wait_ack;
        end
        lf_wait_ack:
          if (ack_i) begin
            cyc_q <= 1'b0;
            state <= lf_wait_nack;
          end
        lf_wait_nack:
          if (!ack_i) begin
            if (beat_cnt == 2'(BEATS-1)) begin
              done_o <= 1'b1;
              state  <= lf_idle;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
              state    <= lf_strobe;
            end
          end
        default: state <= lf_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lf_idle && start_i)
      line_base <= line_adr_i[ADDR_W-1:OFS_W];
    if (state == lf_wait_ack && ack_i)
      line_o[beat_cnt*BEAT_W +: BEAT_W] <= dat_i;   // beat into its slot
  end

endmodule

// File: hdl/line_ram.sv
`timescale 1ns/1ps

module line_ram import mem_pkg::*; (
  input  logic             clk,
  input  logic             wr_i,
  input  way_t             wr_way_i,
  input  logic [IDX_W-1:0] wr_idx_i,
  input  line_t            wr_line_i,
  input  way_t             rd_way_i,
  input  logic [IDX_W-1:0] rd_idx_i,
  output line_t            rd_line_o
);

  // one entry per way and set, way in the upper address bits
  line_t mem [WAYS*SETS];

  always_ff @(posedge clk) begin
    if (wr_i)
      mem[{wr_way_i, wr_idx_i}] <= wr_line_i;
  end

  assign rd_line_o = mem[{rd_way_i, rd_idx_i}];   // async read

endmodule

// File: hdl/cache_tags.sv
`timescale 1ns/1ps

module cache_tags import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t lookup_adr_i,
  input  logic  fill_i,
  input  addr_t fill_adr_i,
  output logic  hit_o,
  output way_t  hit_way_o,
  output way_t  victim_way_o
);

  logic [TAG_W-1:0] tags [WAYS][SETS];
  logic [SETS-1:0]  valid [WAYS];
  logic [16:0]      lfsr;
  logic [WAYS-1:0]  way_hit;
  logic [IDX_W-1:0] lk_idx;
  logic [IDX_W-1:0] fl_idx;

  assign lk_idx = lookup_adr_i[OFS_W +: IDX_W];
  assign fl_idx = fill_adr_i[OFS_W +: IDX_W];

  // compare all ways of the set at once
  always_comb begin
    for (int w = 0; w < WAYS; w++)
      way_hit[w] = valid[w][lk_idx] && (tags[w][lk_idx] == lookup_adr_i[ADDR_W-1:OFS_W]);
  end

  assign hit_o = |way_hit;

  always_comb begin
    hit_way_o = '0;
    for (int w = WAYS-1; w >= 0; w--)
      if (way_hit[w])
        hit_way_o = way_t'(w);   // lowest way wins
  end

  assign victim_way_o = lfsr[1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++)
        valid[w] <= '0;
      lfsr <= 17'h1;
    end else begin
      lfsr <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};   // x^17 + x^14 + 1
      if (fill_i)
        valid[victim_way_o][fl_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i)
      tags[victim_way_o][fl_idx] <= fill_adr_i[ADDR_W-1:OFS_W];
  end

endmodule

// File: hdl/mem_pkg.sv
package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int LINE_W = 512;
  localparam int BEAT_W = 128;
  localparam int SEL_W  = 16;
  localparam int BEATS  = 4;     // beats per line
  localparam int DATA_W = 64;    // load result / store data
  localparam int WAYS   = 4;
  localparam int SETS   = 64;
  localparam int OFS_W  = $clog2(LINE_W/8);   // byte offset within a line
  localparam int IDX_W  = 6;     // address bits 11..6
  localparam int TAG_W  = ADDR_W - OFS_W;     // address bits 31..6
  localparam int IO_BIT = 31;    // set means uncacheable

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [BEAT_W-1:0] beat_t;
  typedef logic [1:0]        way_t;

  typedef enum logic {
    op_load,
    op_store
  } mem_op_e;

  // unsigned forms only matter for loads
  typedef enum logic [2:0] {
    f_byte,
    f_half,
    f_word,
    f_dword,
    f_ubyte,
    f_uhalf,
    f_uword
  } mem_func_e;

endpackage
